// ==== Makefile ====
TOP = vga_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
logic/vga_bus_pkg.sv
logic/vga_disp_pkg.sv
logic/bit_sync.sv
logic/mcp_sync.sv
logic/dac_ram.sv
logic/dac_port.sv
logic/vga_registers.sv
logic/vga_top.sv
dv/vga_checker.sv
dv/vga_tb.sv

// ==== dv/vga_checker.sv ====
`timescale 1ns/100ps

module vga_checker (
    input  logic clk,
    input  logic vga_clk,
    input  logic reset,
    input  logic cs,
    input  logic access,
    input  logic ack,
    input  logic a_send,
    input  logic a_ready,
    input  logic b_load
);

    // ack strobe exactly one clk cycle after each access
    ack_follows_access: assert property (
        @(posedge clk) disable iff (reset) (cs && access) |=> ack
    ) else $error("ack missing one cycle after an access");

    ack_only_after_access: assert property (
        @(posedge clk) disable iff (reset) ack |-> $past(cs && access)
    ) else $error("ack without an access in the previous cycle");

    // the handshake takes a new word only when idle and turns busy right after
    send_while_ready: assert property (
        @(posedge clk) disable iff (reset) a_send |-> a_ready ##1 !a_ready
    ) else $error("a_send while a_ready is low, or a_ready stayed high after a_send");

    b_load_single_cycle: assert property (
        @(posedge vga_clk) disable iff (reset) b_load |=> !b_load
    ) else $error("b_load high for more than one vga_clk cycle");

endmodule

bind vga_registers vga_checker i_checker (
    .clk     (clk),
    .vga_clk (vga_clk),
    .reset   (reset),
    .cs      (cs),
    .access  (req.access),
    .ack     (rsp.ack),
    .a_send  (cfg_send),
    .a_ready (cfg_ready),
    .b_load  (cfg_load)
);

// ==== dv/vga_tb.sv ====
`timescale 1ns/100ps

module vga_tb
    import vga_bus_pkg::*;
    import vga_disp_pkg::*;
();

    localparam int DAC_DEPTH_LOG2 = 8;
    localparam int ACK_TIMEOUT    = 8;
    localparam int CFG_TIMEOUT    = 20;
    localparam int DAC_TIMEOUT    = 2;

    logic                      clk;
    logic                      vga_clk;
    logic                      reset;
    logic                      cs;
    bus_req_t                  req;
    bus_rsp_t                  rsp;
    logic                      vga_hsync;
    logic                      vga_vsync;
    logic [DAC_DEPTH_LOG2-1:0] vga_dac_idx;
    logic [DAC_ENTRY_W-1:0]    vga_dac_rd;
    disp_flags_t               flags;
    disp_cfg_t                 cfg;

    int          fd;
    int          fields;
    int          code;
    int          tests_done;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    logic        timeout_hit;
    logic [31:0] rng;
    logic [7:0]  op;
    logic [31:0] port;
    logic [31:0] data;
    logic [31:0] expected;
    logic [7:0]  rd_value;
    logic [8*96-1:0] line_buf;

    vga_top #(
        .DAC_DEPTH_LOG2 (DAC_DEPTH_LOG2)
    ) i_dut (
        .clk         (clk),
        .vga_clk     (vga_clk),
        .reset       (reset),
        .cs          (cs),
        .req         (req),
        .rsp         (rsp),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_dac_idx (vga_dac_idx),
        .vga_dac_rd  (vga_dac_rd),
        .flags       (flags),
        .cfg         (cfg)
    );

    always begin
        #50 clk = ~clk;
    end

    // display clock has the same period, shifted by 37 ns
    always begin
        #37;
        forever begin
            #50 vga_clk = ~vga_clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] display_value(input logic [31:0] what);
        case (what)
            0:       return {7'b0, cfg};
            1:       return {27'b0, flags};
            default: return {14'b0, vga_dac_rd};
        endcase
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic count_check();
        check_count++;
        test_checks++;
    endtask

    // 0 to 3 idle clk cycles before a bus access
    task automatic random_gap();
        rng = lcg_next(rng);
        repeat (rng[17:16]) @(posedge clk);
    endtask

    // one-cycle strobe, then wait for ack and return the byte lane of the port
    task automatic bus_access(input logic wr, input logic [11:0] io_port,
                              input logic [7:0] value, output logic [7:0] lane);
        int waited;
        @(posedge clk);
        #10;
        cs          = 1'b1;
        req.access  = 1'b1;
        req.wr_en   = wr;
        req.addr    = io_port[5:1];
        req.bytesel = io_port[0] ? 2'b10 : 2'b01;
        req.data    = io_port[0] ? {value, 8'h00} : {8'h00, value};
        @(posedge clk);
        #10;
        cs         = 1'b0;
        req.access = 1'b0;
        req.wr_en  = 1'b0;
        waited     = 1;
        while (!rsp.ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #10;
            waited++;
        end
        lane = io_port[0] ? rsp.data[15:8] : rsp.data[7:0];
        if (!rsp.ack) begin
            $display("timeout: no ack within %0d clk cycles of the access to port %h",
                     ACK_TIMEOUT, io_port);
            count_error();
            timeout_hit = 1'b1;
        end else begin
            count_check();
            if (waited != 1) begin
                $display("ERROR %0t: ack for port %h came after %0d cycles, expected 1",
                         $time, io_port, waited);
                count_error();
            end
        end
    endtask

    // bit 1 vsync, bit 0 hsync; the two-flop synchronizer needs two clk edges
    task automatic set_sync(input logic [1:0] value);
        @(posedge clk);
        #10;
        vga_vsync = value[1];
        vga_hsync = value[0];
        repeat (3) @(posedge clk);
    endtask

    task automatic check_display(input logic [31:0] what, input logic [31:0] idx,
                                 input logic [31:0] exp_value);
        logic [31:0] actual;
        int          limit;
        int          waited;
        limit = (what == 2) ? DAC_TIMEOUT : CFG_TIMEOUT;
        if (what == 2) begin
            @(posedge vga_clk);
            #10;
            vga_dac_idx = idx[DAC_DEPTH_LOG2-1:0];
        end
        waited = 0;
        actual = display_value(what);
        while (actual !== exp_value && waited < limit) begin
            @(posedge vga_clk);
            #10;
            waited++;
            actual = display_value(what);
        end
        count_check();
        if (actual !== exp_value) begin
            $display("ERROR %0t: display value %0d (index %h) is %h, expected %h",
                     $time, what, idx, actual, exp_value);
            count_error();
        end
    endtask

    task automatic finish_test(input logic [31:0] number);
        $display("test %0d finished: %0d checks, %0d errors",
                 number, test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        clk         = 1'b0;
        vga_clk     = 1'b0;
        reset       = 1'b1;
        cs          = 1'b0;
        req         = '0;
        vga_hsync   = 1'b0;
        vga_vsync   = 1'b0;
        vga_dac_idx = '0;
        tests_done  = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        timeout_hit = 1'b0;
        rng         = 32'd56;

        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        fd = $fopen("dv/vga_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file dv/vga_testdata.txt");
            count_error();
        end else begin
            while (!$feof(fd) && !timeout_hit) begin
                code = $fgets(line_buf, fd);
                if (code != 0) begin
                    fields = $sscanf(line_buf, "%s %h %h %h", op, port, data, expected);
                    if (fields == 4 && op != "#") begin
                        case (op)
                            "w": begin
                                random_gap();
                                bus_access(1'b1, port[11:0], data[7:0], rd_value);
                            end
                            "r": begin
                                random_gap();
                                bus_access(1'b0, port[11:0], 8'h00, rd_value);
                                if (!timeout_hit) begin
                                    count_check();
                                    if (rd_value !== expected[7:0]) begin
                                        $display("ERROR %0t: port %h read %h, expected %h",
                                                 $time, port[11:0], rd_value, expected[7:0]);
                                        count_error();
                                    end
                                end
                            end
                            "s": set_sync(data[1:0]);
                            "d": check_display(port, data, expected);
                            "e": finish_test(port);
                            default: begin
                                $display("unknown operation in the test data file");
                                count_error();
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
        if (error_count == 0 && !timeout_hit) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== dv/vga_testdata.txt ====
# op port data expected, all hex; w write, r read, s sync, d display check, e end of test
# s data bit 1 vsync, bit 0 hsync; d port 0 cfg, 1 flags, 2 palette entry at index data
w 3d4 0a 0
w 3d5 2d 0
r 3d4 0 0a
r 3d5 0 25
w 3d4 0b 0
w 3d5 fe 0
r 3d5 0 06
w 3d4 0e 0
w 3d5 93 0
r 3d5 0 13
w 3d4 0f 0
w 3d5 a7 0
r 3d5 0 a7
e 1 0 0
r 3d8 0 09
w 3d8 1a 0
r 3d8 0 0a
w 3d9 f6 0
r 3d9 0 36
w 3c0 41 0
r 3c0 0 41
e 2 0 0
w 3c8 05 0
w 3c9 2a 0
w 3c9 15 0
w 3c9 3f 0
w 3c9 01 0
w 3c9 02 0
w 3c9 03 0
w 3c7 05 0
r 3c9 0 2a
r 3c9 0 15
r 3c9 0 3f
r 3c9 0 01
r 3c9 0 02
r 3c9 0 03
e 3 0 0
d 2 05 2a57f
d 2 06 01083
e 4 0 0
d 0 0 0
s 0 3 0
d 0 0 4e9ee6
d 1 0 1f
s 0 1 0
w 3c0 00 0
d 1 0 1e
w 3c0 41 0
w 3d4 0f 0
w 3d5 00 0
d 0 0 4e9ee6
s 0 3 0
d 0 0 4c02e6
d 1 0 1f
s 0 1 0
e 5 0 0
s 0 0 0
r 3da 0 01
s 0 1 0
r 3da 0 01
s 0 2 0
r 3da 0 09
s 0 3 0
r 3da 0 08
e 6 0 0

// ==== logic/bit_sync.sv ====
`timescale 1ns/100ps

module bit_sync (
    input  logic clk,
    input  logic reset,
    input  logic d,
    output logic q
);

    logic meta;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            meta <= 1'b0;
            q    <= 1'b0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

// ==== logic/dac_port.sv ====
`timescale 1ns/100ps

module dac_port
    import vga_bus_pkg::*;
    import vga_disp_pkg::*;
#(
    parameter int DAC_DEPTH_LOG2 = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  bus_req_t                  req,
    input  reg_sel_e                  sel,
    output logic [5:0]                rd_component,
    output logic                      wr_en_ram,
    output logic [DAC_DEPTH_LOG2-1:0] ram_addr,
    output logic [DAC_ENTRY_W-1:0]    ram_wdata,
    input  logic [DAC_ENTRY_W-1:0]    ram_q
);

    logic [DAC_DEPTH_LOG2-1:0] wr_idx;
    logic [DAC_DEPTH_LOG2-1:0] rd_idx;
    dac_phase_e                wr_phase;
    dac_phase_e                rd_phase;
    logic [11:0]               rg_hold;
    logic                      dac_write;
    logic                      dac_read;

    function automatic dac_phase_e next_phase(input dac_phase_e p);
        case (p)
            phase_red:   return phase_green;
            phase_green: return phase_blue;
            default:     return phase_red;
        endcase
    endfunction

    assign dac_write = (sel == sel_dac_data) && req.wr_en;
    assign dac_read  = (sel == sel_dac_data) && !req.wr_en;

    // blue write commits red and green from the holding register
    assign wr_en_ram = dac_write && (wr_phase == phase_blue);
    assign ram_wdata = {rg_hold, req.data[13:8]};
    assign ram_addr  = dac_write ? wr_idx : rd_idx;

    always_comb begin
        case (rd_phase)
            phase_green: rd_component = ram_q[11:6];
            phase_blue:  rd_component = ram_q[5:0];
            default:     rd_component = ram_q[17:12];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_idx   <= '0;
            rd_idx   <= '0;
            wr_phase <= phase_red;
            rd_phase <= phase_red;
        end else begin
            if ((sel == sel_dac_wr_idx) && req.wr_en) begin
                wr_idx   <= req.data[DAC_DEPTH_LOG2-1:0];
                wr_phase <= phase_red;
            end else if (dac_write) begin
                wr_phase <= next_phase(wr_phase);
                if (wr_phase == phase_blue) begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end

            // read index sits on the odd byte lane
            if ((sel == sel_dac_rd_idx) && req.wr_en) begin
                rd_idx   <= req.data[8 +: DAC_DEPTH_LOG2];
                rd_phase <= phase_red;
            end else if (dac_read) begin
                rd_phase <= next_phase(rd_phase);
                if (rd_phase == phase_blue) begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dac_write && (wr_phase != phase_blue)) begin
            rg_hold <= {rg_hold[5:0], req.data[13:8]};
        end
    end

endmodule

// ==== logic/dac_ram.sv ====
`timescale 1ns/100ps

module dac_ram
    import vga_disp_pkg::*;
#(
    parameter int DAC_DEPTH_LOG2 = 8
) (
    input  logic                      clk_a,
    input  logic [DAC_DEPTH_LOG2-1:0] addr_a,
    input  logic [DAC_ENTRY_W-1:0]    wdata_a,
    input  logic                      wren_a,
    output logic [DAC_ENTRY_W-1:0]    q_a,
    input  logic                      clk_b,
    input  logic [DAC_DEPTH_LOG2-1:0] addr_b,
    output logic [DAC_ENTRY_W-1:0]    q_b
);

    logic [DAC_ENTRY_W-1:0] mem [0:(1 << DAC_DEPTH_LOG2) - 1];

    // bus port, read returns the old entry on a write cycle
    always_ff @(posedge clk_a) begin
        if (wren_a) begin
            mem[addr_a] <= wdata_a;
        end
        q_a <= mem[addr_a];
    end

    // display port is read only
    always_ff @(posedge clk_b) begin
        q_b <= mem[addr_b];
    end

endmodule

// ==== logic/mcp_sync.sv ====
`timescale 1ns/100ps

module mcp_sync #(
    parameter int WIDTH = 8
) (
    input  logic             reset,
    input  logic             clk_a,
    input  logic             a_send,
    input  logic [WIDTH-1:0] a_datain,
    output logic             a_ready,
    input  logic             clk_b,
    output logic [WIDTH-1:0] b_data,
    output logic             b_load
);

    logic [WIDTH-1:0] a_hold;
    logic             a_req_tog;
    logic             a_ack_sync;
    logic             b_req_sync;
    logic             b_ack_tog;
    logic             b_new;

    // idle once the acknowledge toggle has caught up with the request
    assign a_ready = a_req_tog == a_ack_sync;

    always_ff @(posedge clk_a or posedge reset) begin
        if (reset) begin
            a_req_tog <= 1'b0;
        end else if (a_send && a_ready) begin
            a_req_tog <= ~a_req_tog;
        end
    end

    // word stays put until the acknowledge returns
    always_ff @(posedge clk_a) begin
        if (a_send && a_ready) begin
            a_hold <= a_datain;
        end
    end

    bit_sync i_req_sync (
        .clk   (clk_b),
        .reset (reset),
        .d     (a_req_tog),
        .q     (b_req_sync)
    );

    assign b_new = b_req_sync != b_ack_tog;

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            b_ack_tog <= 1'b0;
            b_load    <= 1'b0;
        end else begin
            b_ack_tog <= b_req_sync;
            b_load    <= b_new;
        end
    end

    always_ff @(posedge clk_b) begin
        if (b_new) begin
            b_data <= a_hold;
        end
    end

    bit_sync i_ack_sync (
        .clk   (clk_a),
        .reset (reset),
        .d     (b_ack_tog),
        .q     (a_ack_sync)
    );

endmodule

// ==== logic/vga_bus_pkg.sv ====
package vga_bus_pkg;

    // addr holds bits 5:1 of the I/O port, bytesel picks the even or odd byte
    // even ports (3D4, 3D8, 3DA, 3C0, 3C8) use bytesel[0] and data[7:0]
    // odd ports (3D5, 3D9, 3C7, 3C9) use bytesel[1] and data[15:8]
    typedef struct packed {
        logic        access;
        logic        wr_en;
        logic [4:0]  addr;
        logic [1:0]  bytesel;
        logic [15:0] data;
    } bus_req_t;

    // ack and data are valid one clk cycle after the request
    typedef struct packed {
        logic        ack;
        logic [15:0] data;
    } bus_rsp_t;

    // decoded register of the current access
    typedef enum logic [3:0] {
        sel_none,
        sel_crtc_index,
        sel_crtc_data,
        sel_mode,
        sel_color,
        sel_status,
        sel_amcr,
        sel_dac_rd_idx,
        sel_dac_wr_idx,
        sel_dac_data
    } reg_sel_e;

endpackage

// ==== logic/vga_disp_pkg.sv ====
package vga_disp_pkg;

    // one palette entry is red, green and blue, 6 bits each
    localparam int DAC_ENTRY_W = 18;

    // settings carried to vga_clk through the handshake, once per frame
    typedef struct packed {
        logic [14:0] cursor_pos;
        logic [2:0]  cursor_scan_start;
        logic [2:0]  cursor_scan_end;
        logic [3:0]  background_color;
    } disp_cfg_t;

    // each bit has its own two-flop synchronizer
    typedef struct packed {
        logic cursor_enabled;
        logic graphics_enabled;
        logic bright_colors;
        logic palette_sel;
        logic vga_256_color;
    } disp_flags_t;

    // component order for palette reads and writes
    typedef enum logic [1:0] {
        phase_red,
        phase_green,
        phase_blue
    } dac_phase_e;

endpackage

// ==== logic/vga_registers.sv ====
`timescale 1ns/100ps

module vga_registers
    import vga_bus_pkg::*;
    import vga_disp_pkg::*;
#(
    parameter int DAC_DEPTH_LOG2 = 8
) (
    input  logic        clk,
    input  logic        vga_clk,
    input  logic        reset,
    input  logic        cs,
    input  bus_req_t    req,
    output bus_rsp_t    rsp,
    input  logic        vga_hsync,
    input  logic        vga_vsync,
    output disp_flags_t flags,
    output disp_cfg_t   cfg,
    input  logic [5:0]  dac_rd_component,
    output reg_sel_e    dac_sel
);

    // 256-color mode only makes sense with a full palette
    localparam logic FULL_PALETTE = DAC_DEPTH_LOG2 >= 8;

    reg_sel_e    sel;
    logic [3:0]  active_index;
    logic [1:0]  cursor_mode;
    logic [2:0]  cursor_scan_start;
    logic [2:0]  cursor_scan_end;
    logic [14:0] cursor_pos;
    logic        display_enabled;
    logic        text_enabled;
    logic        graphics_enabled;
    logic        palette_sel;
    logic        bright_colors;
    logic [3:0]  background_color;
    logic [7:0]  amcr;

    logic        hsync;
    logic        vsync;
    disp_flags_t sys_flags;
    disp_cfg_t   sys_cfg;
    disp_cfg_t   cfg_data;
    logic        cfg_send;
    logic        cfg_ready;
    logic        cfg_load;
    logic        cfg_armed;

    logic [7:0]  crtc_value;
    logic [7:0]  status;
    logic [15:0] rd_data;

    // address decode, word address bits 5:1 plus the byte lane
    always_comb begin
        sel = sel_none;
        if (cs && req.access) begin
            case ({req.addr, req.bytesel})
                {5'h0a, 2'b01}: sel = sel_crtc_index;
                {5'h0a, 2'b10}: sel = sel_crtc_data;
                {5'h0c, 2'b01}: sel = sel_mode;
                {5'h0c, 2'b10}: sel = sel_color;
                {5'h0d, 2'b01}: sel = sel_status;
                {5'h00, 2'b01}: sel = sel_amcr;
                {5'h03, 2'b10}: sel = sel_dac_rd_idx;
                {5'h04, 2'b01}: sel = sel_dac_wr_idx;
                {5'h04, 2'b10}: sel = sel_dac_data;
                default:        sel = sel_none;
            endcase
        end
    end

    assign dac_sel = sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index      <= '0;
            cursor_mode       <= '0;
            cursor_scan_start <= '0;
            cursor_scan_end   <= '0;
            cursor_pos        <= '0;
            display_enabled   <= 1'b1;
            text_enabled      <= 1'b1;
            graphics_enabled  <= 1'b0;
            palette_sel       <= 1'b0;
            bright_colors     <= 1'b0;
            background_color  <= '0;
            amcr              <= '0;
        end else if (req.wr_en) begin
            case (sel)
                sel_crtc_index: active_index <= req.data[3:0];
                sel_crtc_data: begin
                    case (active_index)
                        4'ha: begin
                            cursor_mode       <= req.data[13:12];
                            cursor_scan_start <= req.data[10:8];
                        end
                        4'hb: cursor_scan_end   <= req.data[10:8];
                        4'he: cursor_pos[14:8]  <= req.data[14:8];
                        4'hf: cursor_pos[7:0]   <= req.data[15:8];
                        default: ;
                    endcase
                end
                // mode bit 3 video enable, bit 1 graphics, bit 0 text
                sel_mode: begin
                    display_enabled  <= req.data[3];
                    graphics_enabled <= req.data[1];
                    text_enabled     <= req.data[0];
                end
                sel_color: begin
                    palette_sel      <= req.data[13];
                    bright_colors    <= req.data[12];
                    background_color <= req.data[11:8];
                end
                sel_amcr: amcr <= req.data[7:0];
                default: ;
            endcase
        end
    end

    bit_sync i_hsync_sync (
        .clk   (clk),
        .reset (reset),
        .d     (vga_hsync),
        .q     (hsync)
    );

    bit_sync i_vsync_sync (
        .clk   (clk),
        .reset (reset),
        .d     (vga_vsync),
        .q     (vsync)
    );

    // flags are registered in clk so each synchronizer sees a clean edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sys_flags <= '0;
        end else begin
            sys_flags.cursor_enabled   <= cursor_mode != 2'b01;
            sys_flags.graphics_enabled <= graphics_enabled;
            sys_flags.bright_colors    <= bright_colors;
            sys_flags.palette_sel      <= palette_sel;
            sys_flags.vga_256_color    <= (amcr == 8'h41) && FULL_PALETTE;
        end
    end

    for (genvar i = 0; i < $bits(disp_flags_t); i++) begin : g_flag_sync
        bit_sync i_flag_sync (
            .clk   (vga_clk),
            .reset (reset),
            .d     (sys_flags[i]),
            .q     (flags[i])
        );
    end

    assign sys_cfg.cursor_pos        = cursor_pos;
    assign sys_cfg.cursor_scan_start = cursor_scan_start;
    assign sys_cfg.cursor_scan_end   = cursor_scan_end;
    assign sys_cfg.background_color  = background_color;

    // one transfer per vsync, rearmed while vsync is low
    assign cfg_send = vsync && cfg_ready && cfg_armed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_armed <= 1'b1;
        end else if (!vsync) begin
            cfg_armed <= 1'b1;
        end else if (cfg_send) begin
            cfg_armed <= 1'b0;
        end
    end

    mcp_sync #(
        .WIDTH ($bits(disp_cfg_t))
    ) i_cfg_sync (
        .reset    (reset),
        .clk_a    (clk),
        .a_send   (cfg_send),
        .a_datain (sys_cfg),
        .a_ready  (cfg_ready),
        .clk_b    (vga_clk),
        .b_data   (cfg_data),
        .b_load   (cfg_load)
    );

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else if (cfg_load) begin
            cfg <= cfg_data;
        end
    end

    // bit 0 display inactive, bit 3 vertical retrace
    assign status = {4'b0, vsync, 2'b0, ~vsync | ~hsync};

    always_comb begin
        case (active_index)
            4'ha:    crtc_value = {2'b0, cursor_mode, 1'b0, cursor_scan_start};
            4'hb:    crtc_value = {5'b0, cursor_scan_end};
            4'he:    crtc_value = {1'b0, cursor_pos[14:8]};
            4'hf:    crtc_value = cursor_pos[7:0];
            default: crtc_value = 8'h00;
        endcase
    end

    always_comb begin
        rd_data = '0;
        if (!req.wr_en) begin
            case (sel)
                sel_crtc_index: rd_data[7:0]  = {4'b0, active_index};
                sel_crtc_data:  rd_data[15:8] = crtc_value;
                sel_mode:       rd_data[7:0]  = {4'b0, display_enabled, 1'b0,
                                                 graphics_enabled, text_enabled};
                sel_color:      rd_data[15:8] = {2'b0, palette_sel, bright_colors,
                                                 background_color};
                sel_status:     rd_data[7:0]  = status;
                sel_amcr:       rd_data[7:0]  = amcr;
                sel_dac_data:   rd_data[15:8] = {2'b0, dac_rd_component};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.ack  <= cs && req.access;
            rsp.data <= rd_data;
        end
    end

endmodule

// ==== logic/vga_top.sv ====
`timescale 1ns/100ps

module vga_top
    import vga_bus_pkg::*;
    import vga_disp_pkg::*;
#(
    parameter int DAC_DEPTH_LOG2 = 8
) (
    input  logic                      clk,
    input  logic                      vga_clk,
    input  logic                      reset,
    input  logic                      cs,
    input  bus_req_t                  req,
    output bus_rsp_t                  rsp,
    input  logic                      vga_hsync,
    input  logic                      vga_vsync,
    input  logic [DAC_DEPTH_LOG2-1:0] vga_dac_idx,
    output logic [DAC_ENTRY_W-1:0]    vga_dac_rd,
    output disp_flags_t               flags,
    output disp_cfg_t                 cfg
);

    reg_sel_e                  dac_sel;
    logic [5:0]                dac_rd_component;
    logic                      ram_wren;
    logic [DAC_DEPTH_LOG2-1:0] ram_addr;
    logic [DAC_ENTRY_W-1:0]    ram_wdata;
    logic [DAC_ENTRY_W-1:0]    ram_q;

    vga_registers #(
        .DAC_DEPTH_LOG2 (DAC_DEPTH_LOG2)
    ) i_registers (
        .clk              (clk),
        .vga_clk          (vga_clk),
        .reset            (reset),
        .cs               (cs),
        .req              (req),
        .rsp              (rsp),
        .vga_hsync        (vga_hsync),
        .vga_vsync        (vga_vsync),
        .flags            (flags),
        .cfg              (cfg),
        .dac_rd_component (dac_rd_component),
        .dac_sel          (dac_sel)
    );

    dac_port #(
        .DAC_DEPTH_LOG2 (DAC_DEPTH_LOG2)
    ) i_dac_port (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .sel          (dac_sel),
        .rd_component (dac_rd_component),
        .wr_en_ram    (ram_wren),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_q        (ram_q)
    );

    // port b belongs to the display logic in vga_clk
    dac_ram #(
        .DAC_DEPTH_LOG2 (DAC_DEPTH_LOG2)
    ) i_dac_ram (
        .clk_a   (clk),
        .addr_a  (ram_addr),
        .wdata_a (ram_wdata),
        .wren_a  (ram_wren),
        .q_a     (ram_q),
        .clk_b   (vga_clk),
        .addr_b  (vga_dac_idx),
        .q_b     (vga_dac_rd)
    );

endmodule
